// ==== flist.f ====
source/eth_fcs_pkg.sv
source/crc32_byte_update.sv
source/crc32_accum.sv
source/fcs_inserter.sv
source/fcs_checker.sv
source/fcs_apb_regs.sv
source/eth_fcs_top.sv
tests/eth_fcs_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the FCS testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module eth_fcs_tb \
    -f flist.f \
    -o eth_fcs_sim

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/eth_fcs_sim

// ==== source/crc32_accum.sv ====
// CRC-32 state register
`timescale 1ns/1ps
`default_nettype none

module crc32_accum (
    input  wire         clk,
    input  wire         reset,
    input  wire         start,
    input  wire         enable,
    input  wire  [7:0]  data,
    output logic [31:0] crc_state
);
    import eth_fcs_pkg::*;

    logic [31:0] crc_base;
    logic [31:0] crc_next;

    // A new frame restarts from the seed and takes its first byte at once
    assign crc_base = start ? CRC_INIT : crc_state;

    crc32_byte_update crc32_byte_update_i (
        .data     (data),
        .crc_in   (crc_base),
        .crc_next (crc_next)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            crc_state <= CRC_INIT;
        end else if (enable) begin
            crc_state <= crc_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/crc32_byte_update.sv ====
// CRC-32 byte update
`timescale 1ns/1ps
`default_nettype none

module crc32_byte_update (
    input  wire  [7:0]  data,
    input  wire  [31:0] crc_in,
    output logic [31:0] crc_next
);
    import eth_fcs_pkg::*;

    logic [31:0] crc;

    // In reflected form the byte enters at the low end
    // and each step shifts toward bit 0
    always_comb begin
        crc = crc_in ^ {24'h00_0000, data};
        for (int i = 0; i < 8; i++) begin
            if (crc[0]) begin
                crc = (crc >> 1) ^ CRC_POLY;
            end else begin
                crc = crc >> 1;
            end
        end
        crc_next = crc;
    end

endmodule

`default_nettype wire

// ==== source/eth_fcs_pkg.sv ====
// Ethernet FCS definitions
`default_nettype none

package eth_fcs_pkg;

    // IEEE 802.3 CRC-32 in reflected form
    localparam logic [31:0] CRC_POLY    = 32'hEDB8_8320;
    localparam logic [31:0] CRC_INIT    = 32'hFFFF_FFFF;

    // Raw state left after a good frame followed by its own FCS
    localparam logic [31:0] CRC_RESIDUE = 32'hDEBB_20E3;

    // Frame counter width
    localparam int CNT_WIDTH = 16;

    // APB register map
    localparam int APB_ADDR_WIDTH = 12;

    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_CTRL     = 12'h000;
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_GOOD_CNT = 12'h004;
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_BAD_CNT  = 12'h008;
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_LAST_FCS = 12'h00C;

endpackage

`default_nettype wire

// ==== source/eth_fcs_top.sv ====
// Ethernet FCS subsystem
`timescale 1ns/1ps
`default_nettype none

module eth_fcs_top (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  tx_in_valid,
    input  wire  [7:0]                           tx_in_data,
    input  wire                                  tx_in_last,
    output logic                                 tx_in_ready,
    output logic                                 tx_out_valid,
    output logic [7:0]                           tx_out_data,
    output logic                                 tx_out_last,
    input  wire                                  tx_out_ready,
    input  wire                                  rx_valid,
    input  wire  [7:0]                           rx_data,
    input  wire                                  rx_last,
    input  wire                                  psel,
    input  wire                                  penable,
    input  wire                                  pwrite,
    input  wire  [eth_fcs_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  wire  [31:0]                          pwdata,
    output logic [31:0]                          prdata,
    output logic                                 pready,
    output logic                                 pslverr
);
    logic        tx_fcs_enable;
    logic        fcs_done;
    logic [31:0] fcs_value;
    logic        frame_done;
    logic        frame_ok;

    fcs_inserter fcs_inserter_i (
        .clk           (clk),
        .reset         (reset),
        .tx_fcs_enable (tx_fcs_enable),
        .tx_in_valid   (tx_in_valid),
        .tx_in_data    (tx_in_data),
        .tx_in_last    (tx_in_last),
        .tx_in_ready   (tx_in_ready),
        .tx_out_valid  (tx_out_valid),
        .tx_out_data   (tx_out_data),
        .tx_out_last   (tx_out_last),
        .tx_out_ready  (tx_out_ready),
        .fcs_done      (fcs_done),
        .fcs_value     (fcs_value)
    );

    fcs_checker fcs_checker_i (
        .clk        (clk),
        .reset      (reset),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_last    (rx_last),
        .frame_done (frame_done),
        .frame_ok   (frame_ok)
    );

    fcs_apb_regs fcs_apb_regs_i (
        .clk           (clk),
        .reset         (reset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .tx_fcs_enable (tx_fcs_enable),
        .fcs_done      (fcs_done),
        .fcs_value     (fcs_value),
        .frame_done    (frame_done),
        .frame_ok      (frame_ok)
    );

endmodule

`default_nettype wire

// ==== source/fcs_apb_regs.sv ====
// FCS APB register block
`timescale 1ns/1ps
`default_nettype none

module fcs_apb_regs (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  psel,
    input  wire                                  penable,
    input  wire                                  pwrite,
    input  wire  [eth_fcs_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  wire  [31:0]                          pwdata,
    output logic [31:0]                          prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic                                 tx_fcs_enable,
    input  wire                                  fcs_done,
    input  wire  [31:0]                          fcs_value,
    input  wire                                  frame_done,
    input  wire                                  frame_ok
);
    import eth_fcs_pkg::*;

    logic                 access;
    logic                 wr_en;
    logic                 addr_hit;
    logic [CNT_WIDTH-1:0] good_cnt;
    logic [CNT_WIDTH-1:0] bad_cnt;
    logic [31:0]          last_fcs;

    // No wait states
    assign pready  = 1'b1;
    assign access  = psel && penable;
    assign wr_en   = access && pwrite;
    assign pslverr = access && !addr_hit;

    always_comb begin
        addr_hit = 1'b1;
        case (paddr)
            ADDR_CTRL:     prdata = {31'd0, tx_fcs_enable};
            ADDR_GOOD_CNT: prdata = 32'(good_cnt);
            ADDR_BAD_CNT:  prdata = 32'(bad_cnt);
            ADDR_LAST_FCS: prdata = last_fcs;
            default: begin
                prdata   = 32'd0;
                addr_hit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_fcs_enable <= 1'b1;
            good_cnt      <= '0;
            bad_cnt       <= '0;
            last_fcs      <= 32'd0;
        end else begin
            if (wr_en && paddr == ADDR_CTRL) begin
                tx_fcs_enable <= pwdata[0];
            end
            // Any write clears a counter, whatever the data
            if (wr_en && paddr == ADDR_GOOD_CNT) begin
                good_cnt <= '0;
            end else if (frame_done && frame_ok && good_cnt != {CNT_WIDTH{1'b1}}) begin
                good_cnt <= good_cnt + 1'b1;
            end
            if (wr_en && paddr == ADDR_BAD_CNT) begin
                bad_cnt <= '0;
            end else if (frame_done && !frame_ok && bad_cnt != {CNT_WIDTH{1'b1}}) begin
                bad_cnt <= bad_cnt + 1'b1;
            end
            if (fcs_done) begin
                last_fcs <= fcs_value;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fcs_checker.sv ====
// Receive FCS checker
`timescale 1ns/1ps
`default_nettype none

module fcs_checker (
    input  wire        clk,
    input  wire        reset,
    input  wire        rx_valid,
    input  wire  [7:0] rx_data,
    input  wire        rx_last,
    output logic       frame_done,
    output logic       frame_ok
);
    import eth_fcs_pkg::*;

    logic        first_byte;
    logic [31:0] crc_state;

    // FCS bytes go through the CRC like any other byte
    crc32_accum crc32_accum_i (
        .clk       (clk),
        .reset     (reset),
        .start     (first_byte),
        .enable    (rx_valid),
        .data      (rx_data),
        .crc_state (crc_state)
    );

    // Next byte after a last byte opens a new frame
    always_ff @(posedge clk) begin
        if (reset) begin
            first_byte <= 1'b1;
        end else if (rx_valid) begin
            first_byte <= rx_last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= rx_valid && rx_last;
        end
    end

    // State register already holds the value after the last byte here,
    // and a following frame only changes it one edge later
    assign frame_ok = frame_done && (crc_state == CRC_RESIDUE);

endmodule

`default_nettype wire

// ==== source/fcs_inserter.sv ====
// Transmit FCS inserter
`timescale 1ns/1ps
`default_nettype none

module fcs_inserter (
    input  wire         clk,
    input  wire         reset,
    input  wire         tx_fcs_enable,
    input  wire         tx_in_valid,
    input  wire  [7:0]  tx_in_data,
    input  wire         tx_in_last,
    output logic        tx_in_ready,
    output logic        tx_out_valid,
    output logic [7:0]  tx_out_data,
    output logic        tx_out_last,
    input  wire         tx_out_ready,
    output logic        fcs_done,
    output logic [31:0] fcs_value
);
    typedef enum logic {
        ST_DATA,
        ST_FCS
    } state_t;

    state_t      state;
    logic [1:0]  byte_idx;
    logic        first_byte;
    logic        in_xfer;
    logic [31:0] crc_state;

    assign in_xfer = tx_in_valid && tx_in_ready;

    crc32_accum crc32_accum_i (
        .clk       (clk),
        .reset     (reset),
        .start     (first_byte),
        .enable    (in_xfer),
        .data      (tx_in_data),
        .crc_state (crc_state)
    );

    // Accumulator is idle during the FCS phase, so this stays put
    assign fcs_value = ~crc_state;

    always_comb begin
        if (state == ST_FCS) begin
            tx_in_ready  = 1'b0;
            tx_out_valid = 1'b1;
            tx_out_data  = fcs_value[{byte_idx, 3'b000} +: 8];
            tx_out_last  = (byte_idx == 2'd3);
        end else begin
            // Zero latency pass-through
            tx_in_ready  = tx_out_ready;
            tx_out_valid = tx_in_valid;
            tx_out_data  = tx_in_data;
            tx_out_last  = tx_in_last && !tx_fcs_enable;
        end
    end

    assign fcs_done = (state == ST_FCS) && (byte_idx == 2'd3) && tx_out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_DATA;
            byte_idx   <= 2'd0;
            first_byte <= 1'b1;
        end else begin
            case (state)
                ST_DATA: begin
                    if (in_xfer) begin
                        first_byte <= tx_in_last;
                        if (tx_in_last && tx_fcs_enable) begin
                            state <= ST_FCS;
                        end
                    end
                end
                ST_FCS: begin
                    // Index wraps back to 0 after the fourth byte
                    if (tx_out_ready) begin
                        byte_idx <= byte_idx + 2'd1;
                        if (byte_idx == 2'd3) begin
                            state <= ST_DATA;
                        end
                    end
                end
                default: state <= ST_DATA;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tests/eth_fcs_tb.sv ====
// FCS subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module eth_fcs_tb;
    import eth_fcs_pkg::*;

    localparam int TIMEOUT_CYCLES = 500;
    localparam int NUM_FRAMES     = 8;

    logic                      clk;
    logic                      reset;
    logic                      tx_in_valid;
    logic [7:0]                tx_in_data;
    logic                      tx_in_last;
    logic                      tx_in_ready;
    logic                      tx_out_valid;
    logic [7:0]                tx_out_data;
    logic                      tx_out_last;
    logic                      tx_out_ready;
    logic                      rx_valid;
    logic [7:0]                rx_data;
    logic                      rx_last;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [31:0]               pwdata;
    logic [31:0]               prdata;
    logic                      pready;
    logic                      pslverr;

    int          seed;
    logic        random_ready;
    logic [7:0]  frame_q[$];
    logic [7:0]  exp_q[$];
    logic [7:0]  got_q[$];
    logic        got_last_q[$];
    logic [7:0]  rx_q[$];
    int          good_expected;
    int          bad_expected;
    logic [31:0] rd_data;
    logic        rd_err;
    logic [31:0] fcs;
    logic [31:0] saved_fcs;
    int          idx;

    eth_fcs_top eth_fcs_top_i (
        .clk          (clk),
        .reset        (reset),
        .tx_in_valid  (tx_in_valid),
        .tx_in_data   (tx_in_data),
        .tx_in_last   (tx_in_last),
        .tx_in_ready  (tx_in_ready),
        .tx_out_valid (tx_out_valid),
        .tx_out_data  (tx_out_data),
        .tx_out_last  (tx_out_last),
        .tx_out_ready (tx_out_ready),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .rx_last      (rx_last),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("[FAIL] %s: expected 0x%08h, actual 0x%08h",
                               name, expected, actual));
        end
    endtask

    task automatic count_wait(inout int cycles, input string what);
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            fail_run({"Timeout: ", what});
        end
    endtask

    // Bit-serial IEEE 802.3 CRC-32 with complemented result
    function automatic logic [31:0] model_fcs(input logic [7:0] data_q[$]);
        logic [31:0] crc;
        logic        fb;
        crc = 32'hFFFF_FFFF;
        foreach (data_q[i]) begin
            for (int j = 0; j < 8; j++) begin
                fb  = crc[0] ^ data_q[i][j];
                crc = crc >> 1;
                if (fb) begin
                    crc = crc ^ 32'hEDB8_8320;
                end
            end
        end
        return ~crc;
    endfunction

    task automatic apb_access(input logic wr, input logic [APB_ADDR_WIDTH-1:0] addr,
                              input logic [31:0] data);
        int cycles;
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            count_wait(cycles, "APB access never saw pready");
        end while (!pready);
        // No wait states, so pready is high in the first access cycle
        check_value("APB access cycles", 32'd1, cycles);
        // Read data and error sampled in the access phase
        rd_data = prdata;
        rd_err  = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        apb_access(1'b1, addr, data);
    endtask

    task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] addr);
        apb_access(1'b0, addr, 32'd0);
    endtask

    task automatic read_check(input string name, input logic [APB_ADDR_WIDTH-1:0] addr,
                              input logic [31:0] expected);
        apb_read(addr);
        check_value({name, " pslverr"}, 32'd0, {31'd0, rd_err});
        check_value(name, expected, rd_data);
    endtask

    task automatic make_frame();
        int len;
        len = 1 + ($unsigned($random(seed)) % 20);
        frame_q.delete();
        repeat (len) begin
            frame_q.push_back(8'($random(seed)));
        end
    endtask

    task automatic send_tx_frame();
        int cycles;
        foreach (frame_q[i]) begin
            tx_in_valid <= 1'b1;
            tx_in_data  <= frame_q[i];
            tx_in_last  <= (i == frame_q.size() - 1);
            cycles = 0;
            do begin
                @(posedge clk);
                count_wait(cycles, "tx input byte was never accepted");
            end while (!tx_in_ready);
        end
        tx_in_valid <= 1'b0;
        tx_in_last  <= 1'b0;
    endtask

    task automatic collect_tx_frame();
        int   cycles;
        logic done;
        got_q.delete();
        got_last_q.delete();
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clk);
            count_wait(cycles, "tx output frame never ended with last");
            if (tx_out_valid && tx_out_ready) begin
                got_q.push_back(tx_out_data);
                got_last_q.push_back(tx_out_last);
                done = tx_out_last;
            end
            if (random_ready) begin
                tx_out_ready <= 1'($random(seed));
            end else begin
                tx_out_ready <= 1'b1;
            end
        end
    endtask

    task automatic run_tx_frame(input string name, input logic fcs_on, input logic rand_ready);
        logic [31:0] frame_fcs;
        random_ready = rand_ready;
        exp_q = frame_q;
        if (fcs_on) begin
            frame_fcs = model_fcs(frame_q);
            for (int k = 0; k < 4; k++) begin
                exp_q.push_back(frame_fcs[8*k +: 8]);
            end
        end
        if (!rand_ready) begin
            tx_out_ready <= 1'b1;
        end
        fork
            send_tx_frame();
            collect_tx_frame();
        join
        check_value({name, " length"}, exp_q.size(), got_q.size());
        foreach (exp_q[i]) begin
            check_value($sformatf("%s byte %0d", name, i), exp_q[i], got_q[i]);
            check_value($sformatf("%s last %0d", name, i),
                        {31'd0, i == exp_q.size() - 1}, {31'd0, got_last_q[i]});
        end
    endtask

    task automatic send_rx_frame(input string name, input logic ok_expected);
        int cycles;
        foreach (rx_q[i]) begin
            rx_valid <= 1'b1;
            rx_data  <= rx_q[i];
            rx_last  <= (i == rx_q.size() - 1);
            @(posedge clk);
        end
        rx_valid <= 1'b0;
        rx_last  <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            count_wait(cycles, "rx frame_done never pulsed");
        end while (!eth_fcs_top_i.frame_done);
        // frame_done follows the last byte by one cycle
        check_value({name, " frame_done delay"}, 32'd1, cycles);
        check_value({name, " frame_ok"}, {31'd0, ok_expected},
                    {31'd0, eth_fcs_top_i.frame_ok});
    endtask

    initial begin
        seed          = 32'h1b3875d5;
        reset         = 1'b1;
        tx_in_valid   = 1'b0;
        tx_in_data    = 8'd0;
        tx_in_last    = 1'b0;
        tx_out_ready  = 1'b1;
        rx_valid      = 1'b0;
        rx_data       = 8'd0;
        rx_last       = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = 32'd0;
        random_ready  = 1'b0;
        good_expected = 0;
        bad_expected  = 0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // Model against the standard check string
        frame_q = '{8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36, 8'h37, 8'h38, 8'h39};
        check_value("model check value", 32'hCBF4_3926, model_fcs(frame_q));

        // Reset state
        check_value("reset tx_out_valid", 32'd0, {31'd0, tx_out_valid});
        read_check("reset CTRL", ADDR_CTRL, 32'd1);
        read_check("reset GOOD_CNT", ADDR_GOOD_CNT, 32'd0);
        read_check("reset BAD_CNT", ADDR_BAD_CNT, 32'd0);
        read_check("reset LAST_FCS", ADDR_LAST_FCS, 32'd0);

        // Each frame once with steady ready, then again under back-pressure
        for (int n = 0; n < NUM_FRAMES; n++) begin
            make_frame();
            run_tx_frame("fcs append", 1'b1, 1'b0);
            read_check("fcs append LAST_FCS", ADDR_LAST_FCS, model_fcs(frame_q));
            run_tx_frame("back-pressure", 1'b1, 1'b1);
            read_check("back-pressure LAST_FCS", ADDR_LAST_FCS, model_fcs(frame_q));
        end

        // Pass-through with FCS off
        saved_fcs = model_fcs(frame_q);
        apb_write(ADDR_CTRL, 32'd0);
        read_check("disable CTRL", ADDR_CTRL, 32'd0);
        for (int n = 0; n < NUM_FRAMES / 2; n++) begin
            make_frame();
            run_tx_frame("fcs disabled", 1'b0, 1'b1);
            read_check("fcs disabled LAST_FCS", ADDR_LAST_FCS, saved_fcs);
        end
        apb_write(ADDR_CTRL, 32'd1);

        // Good and corrupted receive frames in turn
        for (int n = 0; n < 2 * NUM_FRAMES; n++) begin
            make_frame();
            fcs  = model_fcs(frame_q);
            rx_q = frame_q;
            for (int k = 0; k < 4; k++) begin
                rx_q.push_back(fcs[8*k +: 8]);
            end
            if (n % 2 == 1) begin
                idx       = $unsigned($random(seed)) % rx_q.size();
                rx_q[idx] = rx_q[idx] ^ (8'h01 << ($unsigned($random(seed)) % 8));
                send_rx_frame("rx bad frame", 1'b0);
                bad_expected++;
            end else begin
                send_rx_frame("rx good frame", 1'b1);
                good_expected++;
            end
            read_check("rx GOOD_CNT", ADDR_GOOD_CNT, good_expected);
            read_check("rx BAD_CNT", ADDR_BAD_CNT, bad_expected);
        end

        // Counter clear and unmapped address
        apb_write(ADDR_GOOD_CNT, 32'hFFFF_FFFF);
        read_check("cleared GOOD_CNT", ADDR_GOOD_CNT, 32'd0);
        apb_write(ADDR_BAD_CNT, 32'h0000_0001);
        read_check("cleared BAD_CNT", ADDR_BAD_CNT, 32'd0);
        apb_read(12'h010);
        check_value("unmapped address pslverr", 32'd1, {31'd0, rd_err});

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
